// ==== compile.f ====
+incdir+tests
rtl/vdec_pkg.sv
rtl/vector_control_unit.sv
rtl/element_counter.sv
rtl/operand_offset_gen.sv
rtl/decode_execute_latch.sv
rtl/vector_decode_stage.sv
tests/tb_vector_decode_stage.sv

// ==== rtl/decode_execute_latch.sv ====
module decode_execute_latch
  import vdec_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       stall,
  input  logic       flush,
  input  logic       issue,
  input  vctrl_t     ctrl,
  input  logic       last,
  input  offset_t    vs2_offset0,
  input  offset_t    vs2_offset1,
  input  offset_t    woffset0,
  input  offset_t    woffset1,
  input  logic       wen0,
  input  logic       wen1,
  input  logic       mask0,
  input  logic       mask1,
  input  sew_t       eew,
  input  lane_pair_t vs1_data,
  input  lane_pair_t vs2_data,
  input  lane_pair_t vs3_data,
  input  word_t      xs1,
  input  word_t      xs2,
  input  vtype_t     vtype,
  input  offset_t    vl,
  output de_bundle_t bundle
);

  de_bundle_t nxt;
  de_bundle_t data_q;
  logic       valid_q;
  logic       tail0;
  logic       tail1;

  // lane 1 falls past vl on the final pair of an odd vl
  assign tail0 = (vl == '0);
  assign tail1 = tail0 || (last && vl[0]);

  always_comb begin
    nxt             = '0;
    nxt.valid       = 1'b1;
    nxt.aluop       = ctrl.aluop;
    nxt.vs1         = vs1_data;
    nxt.vs2         = vs2_data;
    nxt.vs3         = vs3_data;
    nxt.imm         = ctrl.is_signed ? {{(XLEN-5){ctrl.imm5[4]}}, ctrl.imm5}
                                     : {{(XLEN-5){1'b0}}, ctrl.imm5};
    nxt.xs1         = xs1;
    nxt.xs2         = xs2;
    nxt.vd          = ctrl.vd;
    nxt.woffset0    = woffset0;
    nxt.woffset1    = woffset1;
    nxt.vs2_offset0 = vs2_offset0;
    nxt.vs2_offset1 = vs2_offset1;
    nxt.wen0        = wen0 && !tail0;
    nxt.wen1        = wen1 && !tail1;
    nxt.mask0       = mask0;
    nxt.mask1       = mask1;
    nxt.eew         = eew;
    nxt.sew         = sew_t'(vtype[5:3]);
    nxt.lmul        = vlmul_t'(vtype[2:0]);
    nxt.vl          = vl;
    nxt.vd_widen    = ctrl.vd_widen;
    nxt.is_masked   = !ctrl.vm;
    nxt.rd_wen      = ctrl.rd_wen;
    nxt.cfgsel      = ctrl.cfgsel;
    nxt.next_vtype  = (ctrl.cfgsel != CFG_NONE) ? ctrl.zimm : xs2[7:0];
    nxt.next_avl    = (ctrl.cfgsel == VSETIVLI) ? word_t'(ctrl.imm5) : xs1;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= issue;
    end
  end

  always_ff @(posedge CLK) begin
    if (issue) begin
      data_q <= nxt;
    end
  end

  always_comb begin
    bundle       = data_q;
    bundle.valid = valid_q;
  end

  flush_drops_valid: assert property (
    @(posedge CLK) disable iff (!nRST)
    flush |=> !bundle.valid
  );

endmodule

// ==== rtl/element_counter.sv ====
module element_counter
  import vdec_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  vctrl_t  ctrl,
  input  logic    instr_valid,
  input  logic    stall,
  input  logic    flush,
  input  offset_t vl,
  output offset_t offset,
  output logic    last,
  output logic    instr_done,
  output logic    busy
);

  logic                  advance;
  logic                  issue;
  logic [VLEN_WIDTH:0]   pair_end;

  // one extra bit so offset+LANES cannot wrap below vl
  assign pair_end = {1'b0, offset} + (VLEN_WIDTH + 1)'(LANES);

  assign last = (ctrl.cfgsel != CFG_NONE) || (pair_end >= {1'b0, vl});

  assign advance    = instr_valid && !stall && !flush;
  assign issue      = advance && !ctrl.illegal;
  // illegal words retire in one cycle without issuing
  assign instr_done = advance && (ctrl.illegal || last);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset <= '0;
      busy   <= 1'b0;
    end else if (flush) begin
      offset <= '0;
      busy   <= 1'b0;
    end else if (issue) begin
      if (last) begin
        offset <= '0;
        busy   <= 1'b0;
      end else begin
        offset <= offset + offset_t'(LANES);
        busy   <= 1'b1;
      end
    end
  end

  // vl is held by the source while an instruction is in flight
  offset_below_vl: assert property (
    @(posedge CLK) disable iff (!nRST)
    busy |-> offset < vl
  );

endmodule

// ==== rtl/operand_offset_gen.sv ====
module operand_offset_gen
  import vdec_pkg::*;
(
  input  vctrl_t     ctrl,
  input  offset_t    offset,
  input  logic       last,
  input  word_t      xs1,
  input  vtype_t     vtype,
  input  logic [1:0] v0_mask,
  input  lane_pair_t vs1_data,
  output rf_read_t   vs1_rd,
  output rf_read_t   vs2_rd,
  output rf_read_t   vs3_rd,
  output sew_t       vs2_sew,
  output offset_t    woffset0,
  output offset_t    woffset1,
  output offset_t    vs2_offset1,
  output logic       wen0,
  output logic       wen1,
  output logic       mask0,
  output logic       mask1,
  output sew_t       eew
);

  sew_t    sew;
  offset_t idx1;
  offset_t rs1_off;
  offset_t uimm_off;
  offset_t vs2_offset0;

  // one step up, SEW32 is the ceiling
  function automatic sew_t widen(input sew_t s);
    case (s)
      SEW8:         widen = SEW16;
      SEW16, SEW32: widen = SEW32;
      default:      widen = s;
    endcase
  endfunction

  assign sew      = sew_t'(vtype[5:3]);
  assign idx1     = offset + offset_t'(1);
  assign rs1_off  = xs1[VLEN_WIDTH-1:0];
  assign uimm_off = offset_t'(ctrl.imm5);

  assign eew     = ctrl.vd_widen ? widen(sew) : sew;
  assign vs2_sew = ctrl.win ? widen(sew) : sew;

  always_comb begin
    case (ctrl.vs2_src)
      VS2_SRC_NORMAL:        {vs2_offset0, vs2_offset1} = {offset, idx1};
      VS2_SRC_IDX_PLUS_RS1:  {vs2_offset0, vs2_offset1} = {offset + rs1_off, idx1 + rs1_off};
      VS2_SRC_IDX_PLUS_UIMM: {vs2_offset0, vs2_offset1} = {offset + uimm_off, idx1 + uimm_off};
      VS2_SRC_IDX_PLUS_1:    {vs2_offset0, vs2_offset1} = {idx1, idx1 + offset_t'(1)};
      // gather indices come straight from the vs1 lanes
      VS2_SRC_VS1: begin
        vs2_offset0 = vs1_data.lane0[VLEN_WIDTH-1:0];
        vs2_offset1 = vs1_data.lane1[VLEN_WIDTH-1:0];
      end
      VS2_SRC_RS1:           {vs2_offset0, vs2_offset1} = {rs1_off, rs1_off};
      VS2_SRC_UIMM:          {vs2_offset0, vs2_offset1} = {uimm_off, uimm_off};
      default:               {vs2_offset0, vs2_offset1} = '0;
    endcase
  end

  always_comb begin
    case (ctrl.vd_src)
      VD_SRC_NORMAL:        {woffset0, woffset1} = {offset, idx1};
      VD_SRC_IDX_PLUS_RS1:  {woffset0, woffset1} = {offset + rs1_off, idx1 + rs1_off};
      VD_SRC_IDX_PLUS_UIMM: {woffset0, woffset1} = {offset + uimm_off, idx1 + uimm_off};
      default:              {woffset0, woffset1} = '0;
    endcase
  end

  always_comb begin
    mask0 = ctrl.vm | v0_mask[0];
    mask1 = ctrl.vm | v0_mask[1];
    if (ctrl.vd_src == VD_SRC_ZERO) begin
      // single element at offset 0, written once on the final pair
      wen0 = ctrl.wen & mask0 & last;
      wen1 = 1'b0;
    end else begin
      wen0 = ctrl.wen & mask0;
      wen1 = ctrl.wen & mask1;
    end
  end

  assign vs1_rd.sel    = ctrl.vs1;
  assign vs1_rd.offset = (ctrl.vs1_src == VS1_SRC_ZERO) ? '0 : offset;
  assign vs2_rd.sel    = ctrl.vs2;
  assign vs2_rd.offset = vs2_offset0;
  // old vd contents, read where the write lands
  assign vs3_rd.sel    = ctrl.vd;
  assign vs3_rd.offset = woffset0;

endmodule

// ==== rtl/vdec_pkg.sv ====
package vdec_pkg;

  localparam int XLEN       = 32;
  localparam int VLEN       = 128;
  // 16 elements at SEW8, one extra bit for the lane-1 index
  localparam int VLEN_WIDTH = $clog2(VLEN / 8) + 1;
  localparam int LANES      = 2;

  // OP-V major opcode and its minor fields
  localparam logic [6:0] OP_V     = 7'b1010111;
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPMVV = 3'b010;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;
  localparam logic [2:0] F3_OPCFG = 3'b111;

  localparam logic [5:0] F6_VADD       = 6'b000000;
  localparam logic [5:0] F6_VSUB       = 6'b000010;
  localparam logic [5:0] F6_VRGATHER   = 6'b001100;
  localparam logic [5:0] F6_VSLIDEUP   = 6'b001110;
  // also vslide1down under OPMVX
  localparam logic [5:0] F6_VSLIDEDOWN = 6'b001111;
  localparam logic [5:0] F6_VWADDU     = 6'b110000;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [VLEN_WIDTH-1:0] offset_t;
  typedef logic [4:0]            vreg_sel_t;
  typedef logic [4:0]            imm5_t;
  typedef logic [7:0]            vtype_t;

  typedef enum logic [2:0] {SEW8 = 3'b000, SEW16 = 3'b001, SEW32 = 3'b010} sew_t;

  typedef enum logic [2:0] {
    LMUL1   = 3'b000,
    LMUL2   = 3'b001,
    LMUL4   = 3'b010,
    LMUL8   = 3'b011,
    LMUL_F8 = 3'b101,
    LMUL_F4 = 3'b110,
    LMUL_F2 = 3'b111
  } vlmul_t;

  typedef enum logic {VS1_SRC_NORMAL, VS1_SRC_ZERO} vs1_src_t;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL,
    VS2_SRC_IDX_PLUS_RS1,
    VS2_SRC_IDX_PLUS_UIMM,
    VS2_SRC_IDX_PLUS_1,
    VS2_SRC_VS1,
    VS2_SRC_RS1,
    VS2_SRC_UIMM,
    VS2_SRC_ZERO
  } vs2_src_t;

  typedef enum logic [2:0] {
    VD_SRC_NORMAL,
    VD_SRC_ZERO,
    VD_SRC_IDX_PLUS_RS1,
    VD_SRC_IDX_PLUS_UIMM
  } vd_src_t;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS} aluop_t;
  typedef enum logic [1:0] {CFG_NONE, VSETVLI, VSETIVLI} cfg_t;

  typedef struct packed {
    vreg_sel_t vs1;
    vreg_sel_t vs2;
    vreg_sel_t vd;
    imm5_t     imm5;
    // vtype image carried in the zimm field of vset*vli
    vtype_t    zimm;
    logic      vm;
    vs1_src_t  vs1_src;
    vs2_src_t  vs2_src;
    vd_src_t   vd_src;
    aluop_t    aluop;
    cfg_t      cfgsel;
    logic      is_signed;
    logic      vd_widen;
    logic      win;
    logic      wen;
    logic      rd_wen;
    logic      illegal;
  } vctrl_t;

  typedef struct packed {
    word_t lane1;
    word_t lane0;
  } lane_pair_t;

  typedef struct packed {
    vreg_sel_t sel;
    offset_t   offset;
  } rf_read_t;

  typedef struct packed {
    logic       valid;
    aluop_t     aluop;
    lane_pair_t vs1;
    lane_pair_t vs2;
    lane_pair_t vs3;
    word_t      imm;
    word_t      xs1;
    word_t      xs2;
    vreg_sel_t  vd;
    offset_t    woffset0;
    offset_t    woffset1;
    offset_t    vs2_offset0;
    offset_t    vs2_offset1;
    logic       wen0;
    logic       wen1;
    logic       mask0;
    logic       mask1;
    sew_t       eew;
    sew_t       sew;
    vlmul_t     lmul;
    offset_t    vl;
    logic       vd_widen;
    logic       is_masked;
    logic       rd_wen;
    cfg_t       cfgsel;
    vtype_t     next_vtype;
    word_t      next_avl;
  } de_bundle_t;

endpackage

// ==== rtl/vector_control_unit.sv ====
module vector_control_unit
  import vdec_pkg::*;
(
  input  logic   CLK,
  input  logic   nRST,
  input  word_t  instr,
  output vctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       is_ivv;
  logic       is_ivx;
  logic       is_ivi;
  logic       is_mvv;
  logic       is_mvx;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct6 = instr[31:26];

  assign is_ivv = (funct3 == F3_OPIVV);
  assign is_ivx = (funct3 == F3_OPIVX);
  assign is_ivi = (funct3 == F3_OPIVI);
  assign is_mvv = (funct3 == F3_OPMVV);
  assign is_mvx = (funct3 == F3_OPMVX);

  always_comb begin
    ctrl         = '0;
    ctrl.vs1     = instr[19:15];
    ctrl.vs2     = instr[24:20];
    ctrl.vd      = instr[11:7];
    ctrl.imm5    = instr[19:15];
    ctrl.zimm    = instr[27:20];
    ctrl.vm      = instr[25];
    ctrl.vs1_src = VS1_SRC_NORMAL;
    ctrl.vs2_src = VS2_SRC_NORMAL;
    ctrl.vd_src  = VD_SRC_NORMAL;
    ctrl.aluop   = ALU_ADD;
    ctrl.cfgsel  = CFG_NONE;
    ctrl.illegal = 1'b1;

    if (opcode == OP_V && funct3 == F3_OPCFG) begin
      // no vector reads, rd gets the new vl
      ctrl.vs1_src = VS1_SRC_ZERO;
      ctrl.vs2_src = VS2_SRC_ZERO;
      ctrl.vd_src  = VD_SRC_ZERO;
      ctrl.aluop   = ALU_PASS;
      if (!instr[31]) begin
        ctrl.cfgsel  = VSETVLI;
        ctrl.rd_wen  = 1'b1;
        ctrl.illegal = 1'b0;
      end else if (instr[30]) begin
        ctrl.cfgsel  = VSETIVLI;
        ctrl.rd_wen  = 1'b1;
        ctrl.illegal = 1'b0;
      end
    end else if (opcode == OP_V) begin
      // scalar and immediate forms leave vs1 unread
      if (!is_ivv && !is_mvv) begin
        ctrl.vs1_src = VS1_SRC_ZERO;
      end
      case (funct6)
        F6_VADD: begin
          if (is_ivv || is_ivx || is_ivi) begin
            ctrl.is_signed = 1'b1;
            ctrl.wen       = 1'b1;
            ctrl.illegal   = 1'b0;
          end
        end
        F6_VSUB: begin
          if (is_ivv || is_ivx) begin
            ctrl.aluop   = ALU_SUB;
            ctrl.wen     = 1'b1;
            ctrl.illegal = 1'b0;
          end
        end
        F6_VRGATHER: begin
          ctrl.aluop = ALU_PASS;
          if (is_ivv || is_ivx || is_ivi) begin
            ctrl.vs2_src = is_ivv ? VS2_SRC_VS1 : (is_ivx ? VS2_SRC_RS1 : VS2_SRC_UIMM);
            ctrl.wen     = 1'b1;
            ctrl.illegal = 1'b0;
          end
        end
        F6_VSLIDEUP: begin
          ctrl.aluop = ALU_PASS;
          if (is_ivx || is_ivi) begin
            ctrl.vd_src  = is_ivx ? VD_SRC_IDX_PLUS_RS1 : VD_SRC_IDX_PLUS_UIMM;
            ctrl.wen     = 1'b1;
            ctrl.illegal = 1'b0;
          end
        end
        F6_VSLIDEDOWN: begin
          ctrl.aluop = ALU_PASS;
          if (is_ivx || is_ivi || is_mvx) begin
            // OPMVX here is vslide1down
            if (is_mvx) begin
              ctrl.vs2_src = VS2_SRC_IDX_PLUS_1;
            end else begin
              ctrl.vs2_src = is_ivx ? VS2_SRC_IDX_PLUS_RS1 : VS2_SRC_IDX_PLUS_UIMM;
            end
            ctrl.wen     = 1'b1;
            ctrl.illegal = 1'b0;
          end
        end
        F6_VWADDU: begin
          if (is_mvv) begin
            ctrl.vd_widen = 1'b1;
            ctrl.win      = 1'b1;
            ctrl.wen      = 1'b1;
            ctrl.illegal  = 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  // an undecoded word must never reach either register file
  illegal_never_writes: assert property (
    @(posedge CLK) disable iff (!nRST)
    ctrl.illegal |-> !ctrl.wen && !ctrl.rd_wen
  );

endmodule

// ==== rtl/vector_decode_stage.sv ====
module vector_decode_stage
  import vdec_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  word_t      instr,
  input  logic       instr_valid,
  input  vtype_t     vtype,
  input  offset_t    vl,
  input  word_t      xs1,
  input  word_t      xs2,
  input  logic       stall,
  input  logic       flush,
  output rf_read_t   vs1_rd,
  output rf_read_t   vs2_rd,
  output rf_read_t   vs3_rd,
  output sew_t       vs2_sew,
  input  lane_pair_t vs1_data,
  input  lane_pair_t vs2_data,
  input  lane_pair_t vs3_data,
  input  logic [1:0] v0_mask,
  output de_bundle_t bundle,
  output logic       instr_done,
  output logic       busy
);

  vctrl_t  ctrl;
  offset_t offset;
  offset_t woffset0;
  offset_t woffset1;
  offset_t vs2_offset1;
  logic    last;
  logic    issue;
  logic    wen0;
  logic    wen1;
  logic    mask0;
  logic    mask1;
  sew_t    eew;

  // one pair enters the pipe this cycle
  assign issue = instr_valid && !ctrl.illegal && !stall && !flush;

  vector_control_unit vcu (
    .CLK   (CLK),
    .nRST  (nRST),
    .instr (instr),
    .ctrl  (ctrl)
  );

  element_counter counter (
    .CLK         (CLK),
    .nRST        (nRST),
    .ctrl        (ctrl),
    .instr_valid (instr_valid),
    .stall       (stall),
    .flush       (flush),
    .vl          (vl),
    .offset      (offset),
    .last        (last),
    .instr_done  (instr_done),
    .busy        (busy)
  );

  operand_offset_gen offset_gen (
    .ctrl        (ctrl),
    .offset      (offset),
    .last        (last),
    .xs1         (xs1),
    .vtype       (vtype),
    .v0_mask     (v0_mask),
    .vs1_data    (vs1_data),
    .vs1_rd      (vs1_rd),
    .vs2_rd      (vs2_rd),
    .vs3_rd      (vs3_rd),
    .vs2_sew     (vs2_sew),
    .woffset0    (woffset0),
    .woffset1    (woffset1),
    .vs2_offset1 (vs2_offset1),
    .wen0        (wen0),
    .wen1        (wen1),
    .mask0       (mask0),
    .mask1       (mask1),
    .eew         (eew)
  );

  decode_execute_latch de_latch (
    .CLK         (CLK),
    .nRST        (nRST),
    .stall       (stall),
    .flush       (flush),
    .issue       (issue),
    .ctrl        (ctrl),
    .last        (last),
    .vs2_offset0 (vs2_rd.offset),
    .vs2_offset1 (vs2_offset1),
    .woffset0    (woffset0),
    .woffset1    (woffset1),
    .wen0        (wen0),
    .wen1        (wen1),
    .mask0       (mask0),
    .mask1       (mask1),
    .eew         (eew),
    .vs1_data    (vs1_data),
    .vs2_data    (vs2_data),
    .vs3_data    (vs3_data),
    .xs1         (xs1),
    .xs2         (xs2),
    .vtype       (vtype),
    .vl          (vl),
    .bundle      (bundle)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_vector_decode_stage
LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps \
  -f compile.f --top-module "$TOP" -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

grep -q "Simulation PASSED" "$LOG"
exit $?

// ==== tests/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// register-file word, every bit of register and element index takes part
function automatic word_t rf_word(input vreg_sel_t sel, input offset_t off);
  return {3'b110, sel, 3'b011, off, 3'b100, ~sel, 3'b001, off ^ sel};
endfunction

// lane 1 holds the element after the requested one
function automatic lane_pair_t rf_pair(input vreg_sel_t sel, input offset_t off);
  lane_pair_t p;
  p.lane0 = rf_word(sel, off);
  p.lane1 = rf_word(sel, off + offset_t'(1));
  return p;
endfunction

// v0 pattern, a scramble of the whole element index
function automatic logic v0_bit(input offset_t off);
  return off[0] ^ off[2] ^ (off[1] & off[3]) ^ off[4];
endfunction

function automatic sew_t widen_sew(input sew_t s);
  return (s == SEW8) ? SEW16 : SEW32;
endfunction

// vwaddu.vv: funct6 110000 under OPMVV
function automatic logic is_widening(input word_t ins);
  return (ins[31:26] == 6'b110000) && (ins[14:12] == 3'b010);
endfunction

function automatic logic is_cfg_instr(input word_t ins);
  return ins[14:12] == 3'b111;
endfunction

function automatic sew_t expected_vs2_sew(input word_t ins, input vtype_t vt);
  if (is_widening(ins)) begin
    return widen_sew(sew_t'(vt[5:3]));
  end else begin
    return sew_t'(vt[5:3]);
  end
endfunction

// expected execute bundle for one element pair of a legal instruction
function automatic de_bundle_t expected_bundle(input word_t ins, input vtype_t vt,
                                               input offset_t vl_in, input word_t rs1,
                                               input word_t rs2, input int pair);
  de_bundle_t b;
  logic [5:0] f6;
  logic [2:0] f3;
  offset_t    idx;
  offset_t    rs1o;
  offset_t    uimm;
  offset_t    v1off;
  word_t      gw0;
  word_t      gw1;
  logic       cfg;
  b     = '0;
  f6    = ins[31:26];
  f3    = ins[14:12];
  idx   = offset_t'(pair * LANES);
  rs1o  = rs1[VLEN_WIDTH-1:0];
  uimm  = ins[19:15];
  cfg   = is_cfg_instr(ins);
  // .vv forms walk vs1, the rest read element 0
  v1off = (f3 == 3'b000 || f3 == 3'b010) ? idx : '0;
  b.vs2_offset0 = idx;
  b.vs2_offset1 = idx + offset_t'(1);
  b.woffset0    = idx;
  b.woffset1    = idx + offset_t'(1);
  if (cfg) begin
    b.vs2_offset0 = '0;
    b.vs2_offset1 = '0;
    b.woffset0    = '0;
    b.woffset1    = '0;
  end else if (f6 == 6'b001100) begin
    // vrgather picks vs2 elements by index
    gw0 = rf_word(ins[19:15], idx);
    gw1 = rf_word(ins[19:15], idx + offset_t'(1));
    case (f3)
      3'b000:  {b.vs2_offset0, b.vs2_offset1} = {gw0[VLEN_WIDTH-1:0], gw1[VLEN_WIDTH-1:0]};
      3'b100:  {b.vs2_offset0, b.vs2_offset1} = {rs1o, rs1o};
      default: {b.vs2_offset0, b.vs2_offset1} = {uimm, uimm};
    endcase
  end else if (f6 == 6'b001111) begin
    // vslidedown and vslide1down
    case (f3)
      3'b100:  {b.vs2_offset0, b.vs2_offset1} = {idx + rs1o, idx + rs1o + offset_t'(1)};
      3'b011:  {b.vs2_offset0, b.vs2_offset1} = {idx + uimm, idx + uimm + offset_t'(1)};
      default: {b.vs2_offset0, b.vs2_offset1} = {idx + offset_t'(1), idx + offset_t'(2)};
    endcase
  end else if (f6 == 6'b001110) begin
    if (f3 == 3'b100) begin
      {b.woffset0, b.woffset1} = {idx + rs1o, idx + rs1o + offset_t'(1)};
    end else begin
      {b.woffset0, b.woffset1} = {idx + uimm, idx + uimm + offset_t'(1)};
    end
  end
  b.valid = 1'b1;
  if (cfg || f6 == 6'b001100 || f6 == 6'b001110 || f6 == 6'b001111) begin
    b.aluop = ALU_PASS;
  end else if (f6 == 6'b000010) begin
    b.aluop = ALU_SUB;
  end else begin
    b.aluop = ALU_ADD;
  end
  b.vs1 = rf_pair(ins[19:15], v1off);
  b.vs2 = rf_pair(ins[24:20], b.vs2_offset0);
  b.vs3 = rf_pair(ins[11:7], b.woffset0);
  // vadd.vi is the only signed immediate here
  b.imm = (!cfg && f6 == 6'b000000) ? {{(XLEN-5){ins[19]}}, ins[19:15]}
                                    : {{(XLEN-5){1'b0}}, ins[19:15]};
  b.xs1        = rs1;
  b.xs2        = rs2;
  b.vd         = ins[11:7];
  // v0 is read at the lane-0 write offset and the element after it
  b.mask0      = ins[25] | v0_bit(b.woffset0);
  b.mask1      = ins[25] | v0_bit(b.woffset0 + offset_t'(1));
  // a lane writes only while its element index is below vl
  b.wen0       = !cfg && b.mask0 && (int'(idx) < int'(vl_in));
  b.wen1       = !cfg && b.mask1 && (int'(idx) + 1 < int'(vl_in));
  b.sew        = sew_t'(vt[5:3]);
  b.eew        = is_widening(ins) ? widen_sew(b.sew) : b.sew;
  b.lmul       = vlmul_t'(vt[2:0]);
  b.vl         = vl_in;
  b.vd_widen   = is_widening(ins);
  b.is_masked  = !ins[25];
  b.rd_wen     = cfg;
  b.cfgsel     = !cfg ? CFG_NONE : (ins[31] ? VSETIVLI : VSETVLI);
  b.next_vtype = cfg ? ins[27:20] : rs2[7:0];
  b.next_avl   = (b.cfgsel == VSETIVLI) ? {{(XLEN-5){1'b0}}, ins[19:15]} : rs1;
  return b;
endfunction

`endif

// ==== tests/tb_vector_decode_stage.sv ====
module tb_vector_decode_stage
  import vdec_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_VL    = 16;
  localparam int N_BASIC   = 13;
  localparam int N_RANDOM  = 24;
  localparam int N_WIDEN   = 3;
  localparam int N_CFG     = 3;
  localparam int N_STALL   = 6;
  // flushed instruction runs twice
  localparam int N_FLUSH   = 2;
  localparam int NUM_INSTR = N_BASIC + N_RANDOM + N_WIDEN + N_CFG + N_STALL + N_FLUSH;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * (MAX_VL / 2 + 4) * 2 + 50;
  localparam vtype_t VT_SEW32 = 8'h10;

  logic       CLK;
  logic       nRST;
  word_t      instr;
  logic       instr_valid;
  vtype_t     vtype;
  offset_t    vl;
  word_t      xs1;
  word_t      xs2;
  logic       stall;
  logic       flush;
  rf_read_t   vs1_rd;
  rf_read_t   vs2_rd;
  rf_read_t   vs3_rd;
  sew_t       vs2_sew;
  lane_pair_t vs1_data;
  lane_pair_t vs2_data;
  lane_pair_t vs3_data;
  logic [1:0] v0_mask;
  de_bundle_t bundle;
  logic       instr_done;
  logic       busy;

  de_bundle_t exp_q[$];
  int         seed = 32'h74574df0;
  int         cycles = 0;
  logic       stall_q = 1'b0;
  offset_t    vl_list[3] = '{5'd7, 5'd8, 5'd16};

  `include "tb_decode_model.svh"

  vector_decode_stage UUT (.*);

  // register file answers in the same cycle
  assign vs1_data = rf_pair(vs1_rd.sel, vs1_rd.offset);
  assign vs2_data = rf_pair(vs2_rd.sel, vs2_rd.offset);
  assign vs3_data = rf_pair(vs3_rd.sel, vs3_rd.offset);
  assign v0_mask  = {v0_bit(vs3_rd.offset + offset_t'(1)), v0_bit(vs3_rd.offset)};

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Run hung: no completion within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_bundle(input de_bundle_t got, input de_bundle_t exp);
    check_value("bundle.aluop", 64'(got.aluop), 64'(exp.aluop));
    check_value("bundle.vs1", 64'(got.vs1), 64'(exp.vs1));
    check_value("bundle.vs2", 64'(got.vs2), 64'(exp.vs2));
    check_value("bundle.vs3", 64'(got.vs3), 64'(exp.vs3));
    check_value("bundle.imm", 64'(got.imm), 64'(exp.imm));
    check_value("bundle.xs1", 64'(got.xs1), 64'(exp.xs1));
    check_value("bundle.xs2", 64'(got.xs2), 64'(exp.xs2));
    check_value("bundle.vd", 64'(got.vd), 64'(exp.vd));
    check_value("bundle.woffset0", 64'(got.woffset0), 64'(exp.woffset0));
    check_value("bundle.woffset1", 64'(got.woffset1), 64'(exp.woffset1));
    check_value("bundle.vs2_offset0", 64'(got.vs2_offset0), 64'(exp.vs2_offset0));
    check_value("bundle.vs2_offset1", 64'(got.vs2_offset1), 64'(exp.vs2_offset1));
    check_value("bundle.wen0", 64'(got.wen0), 64'(exp.wen0));
    check_value("bundle.wen1", 64'(got.wen1), 64'(exp.wen1));
    check_value("bundle.mask0", 64'(got.mask0), 64'(exp.mask0));
    check_value("bundle.mask1", 64'(got.mask1), 64'(exp.mask1));
    check_value("bundle.eew", 64'(got.eew), 64'(exp.eew));
    check_value("bundle.sew", 64'(got.sew), 64'(exp.sew));
    check_value("bundle.lmul", 64'(got.lmul), 64'(exp.lmul));
    check_value("bundle.vl", 64'(got.vl), 64'(exp.vl));
    check_value("bundle.vd_widen", 64'(got.vd_widen), 64'(exp.vd_widen));
    check_value("bundle.is_masked", 64'(got.is_masked), 64'(exp.is_masked));
    check_value("bundle.rd_wen", 64'(got.rd_wen), 64'(exp.rd_wen));
    check_value("bundle.cfgsel", 64'(got.cfgsel), 64'(exp.cfgsel));
    check_value("bundle.next_vtype", 64'(got.next_vtype), 64'(exp.next_vtype));
    check_value("bundle.next_avl", 64'(got.next_avl), 64'(exp.next_avl));
  endtask

  // a bundle held through a stall is compared only once
  always @(negedge CLK) stall_q <= stall;

  always @(negedge CLK) begin : compare_proc
    de_bundle_t exp_b;
    if (bundle.valid && !stall_q) begin
      if (exp_q.size() == 0) begin
        $display("Bundle valid without any issued pair");
        $display("Simulation FAILED");
        $fatal(1, "unexpected bundle");
      end else begin
        exp_b = exp_q.pop_front();
        compare_bundle(bundle, exp_b);
      end
    end
  end

  function automatic word_t make_op(input logic [5:0] f6, input logic vm, input vreg_sel_t vs2,
                                    input logic [4:0] src1, input logic [2:0] f3,
                                    input vreg_sel_t vd);
    return {f6, vm, vs2, src1, f3, vd, 7'b1010111};
  endfunction

  // holds one instruction until instr_done, checking each cycle at the falling edge
  task automatic run_instr(input word_t ins, input offset_t vl_in, input vtype_t vt,
                           input word_t rs1, input word_t rs2, input logic legal,
                           input logic use_stall, input int flush_pair);
    int   pair;
    logic done;
    logic flushed;
    logic stall_now;
    logic flush_now;
    logic last_exp;
    logic check_gap;
    pair        = 0;
    done        = 1'b0;
    flushed     = 1'b0;
    check_gap   = 1'b0;
    instr       = ins;
    vl          = vl_in;
    vtype       = vt;
    xs1         = rs1;
    xs2         = rs2;
    instr_valid = 1'b1;
    while (!done) begin
      flush_now = !flushed && (pair == flush_pair);
      stall_now = !flush_now && use_stall && (($random(seed) & 3) == 0);
      stall     = stall_now;
      flush     = flush_now;
      @(negedge CLK);
      last_exp = is_cfg_instr(ins) || (pair * LANES + LANES >= int'(vl_in));
      if (check_gap) begin
        check_value("bundle.valid after flush", 64'(bundle.valid), 64'(0));
      end
      check_gap = flush_now;
      check_value("busy", 64'(busy), 64'(pair != 0));
      check_value("vs2_sew", 64'(vs2_sew), 64'(expected_vs2_sew(ins, vt)));
      check_value("instr_done", 64'(instr_done),
                  64'(!stall_now && !flush_now && (!legal || last_exp)));
      if (flush_now) begin
        // source keeps the instruction, it restarts at element 0
        flushed = 1'b1;
        pair    = 0;
      end else if (!stall_now) begin
        if (legal) begin
          exp_q.push_back(expected_bundle(ins, vt, vl_in, rs1, rs2, pair));
          pair++;
        end
        done = !legal || last_exp;
      end
      @(posedge CLK);
      #1;
    end
    stall = 1'b0;
    flush = 1'b0;
  endtask

  task automatic run_random_offset_tests(input int n);
    word_t      r;
    word_t      ins;
    logic [5:0] f6;
    logic [2:0] f3;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    {f6, f3} = {6'b001100, 3'b000};
        3'd1:    {f6, f3} = {6'b001100, 3'b100};
        3'd2:    {f6, f3} = {6'b001100, 3'b011};
        3'd3:    {f6, f3} = {6'b001111, 3'b100};
        3'd4:    {f6, f3} = {6'b001111, 3'b011};
        3'd5:    {f6, f3} = {6'b001111, 3'b110};
        3'd6:    {f6, f3} = {6'b001110, 3'b100};
        default: {f6, f3} = {6'b001110, 3'b011};
      endcase
      ins = make_op(f6, r[3], r[8:4], r[13:9], f3, r[18:14]);
      run_instr(ins, offset_t'(r[22:19]) + offset_t'(1), VT_SEW32, word_t'($random(seed)),
                word_t'($random(seed)), 1'b1, 1'b0, -1);
    end
  endtask

  initial begin
    nRST        = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    vtype       = VT_SEW32;
    vl          = '0;
    xs1         = '0;
    xs2         = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // vadd.vv and vsub.vx, unmasked then masked
    for (int m = 0; m < 2; m++) begin
      for (int k = 0; k < 3; k++) begin
        run_instr(make_op(6'b000000, m == 0, 5'd2, 5'd3, 3'b000, 5'd4), vl_list[k],
                  VT_SEW32, 32'h0000_0011, 32'h0000_0022, 1'b1, 1'b0, -1);
        run_instr(make_op(6'b000010, m == 0, 5'd5, 5'd6, 3'b100, 5'd7), vl_list[k],
                  VT_SEW32, 32'h1234_5678, 32'h0000_0033, 1'b1, 1'b0, -1);
      end
    end
    run_instr(make_op(6'b000000, 1'b1, 5'd2, 5'd3, 3'b000, 5'd4), 5'd0,
              VT_SEW32, 32'h0, 32'h0, 1'b1, 1'b0, -1);

    run_random_offset_tests(N_RANDOM);

    // vwaddu.vv across the three element widths
    for (int s = 0; s < 3; s++) begin
      run_instr(make_op(6'b110000, 1'b1, 5'd8, 5'd9, 3'b010, 5'd10), 5'd8,
                {2'b00, 3'(s), 3'b000}, 32'h0, 32'h0, 1'b1, 1'b0, -1);
    end

    // vsetvli, vsetivli, then vsetvl which is not decoded
    run_instr({1'b0, 3'b000, 8'h0a, 5'd11, 3'b111, 5'd12, 7'b1010111}, 5'd8,
              VT_SEW32, 32'h0000_0019, 32'h0000_00c8, 1'b1, 1'b0, -1);
    run_instr({2'b11, 2'b00, 8'h13, 5'd9, 3'b111, 5'd1, 7'b1010111}, 5'd8,
              VT_SEW32, 32'h0000_0005, 32'h0000_0007, 1'b1, 1'b0, -1);
    run_instr({2'b10, 5'd0, 5'd3, 5'd4, 3'b111, 5'd5, 7'b1010111}, 5'd8,
              VT_SEW32, 32'h0, 32'h0, 1'b0, 1'b0, -1);

    // random stall stretches
    run_instr(make_op(6'b000000, 1'b1, 5'd2, 5'd3, 3'b000, 5'd4), 5'd16,
              VT_SEW32, 32'h0, 32'h0, 1'b1, 1'b1, -1);
    run_instr(make_op(6'b000010, 1'b0, 5'd5, 5'd6, 3'b100, 5'd7), 5'd7,
              VT_SEW32, 32'h0000_0abc, 32'h0, 1'b1, 1'b1, -1);
    run_instr(make_op(6'b001100, 1'b1, 5'd12, 5'd13, 3'b000, 5'd14), 5'd12,
              VT_SEW32, 32'h0, 32'h0, 1'b1, 1'b1, -1);
    run_instr(make_op(6'b001110, 1'b1, 5'd15, 5'd3, 3'b011, 5'd16), 5'd9,
              VT_SEW32, 32'h0, 32'h0, 1'b1, 1'b1, -1);
    run_instr(make_op(6'b110000, 1'b0, 5'd8, 5'd9, 3'b010, 5'd10), 5'd10,
              8'h00, 32'h0, 32'h0, 1'b1, 1'b1, -1);
    run_instr({2'b11, 2'b00, 8'h08, 5'd16, 3'b111, 5'd2, 7'b1010111}, 5'd4,
              VT_SEW32, 32'h0, 32'h0, 1'b1, 1'b1, -1);

    // flush after three pairs of a 16 element add
    run_instr(make_op(6'b000000, 1'b1, 5'd20, 5'd21, 3'b000, 5'd22), 5'd16,
              VT_SEW32, 32'h0, 32'h0, 1'b1, 1'b0, 3);

    instr_valid = 1'b0;
    repeat (3) @(posedge CLK);
    if (exp_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d issued pairs never reached the latch output", exp_q.size());
      $display("Simulation FAILED");
      $fatal(1, "missing bundles");
    end
  end

endmodule
